/* build.f */
hdl/sa_array_pkg.sv
hdl/sa_ctrl_pkg.sv
hdl/simple_dual_port_ram.sv
hdl/dram_to_memory.sv
hdl/dram_access_ctrl.sv
hdl/sa_controller.sv
hdl/systolic_array.sv
hdl/sparhixcel_top.sv
verification/tb_sparhixcel.sv

/* Bender.yml */
package:
  name: sparhixcel

sources:
  - files:
      - hdl/sa_array_pkg.sv
      - hdl/sa_ctrl_pkg.sv
      - hdl/simple_dual_port_ram.sv
      - hdl/dram_to_memory.sv
      - hdl/dram_access_ctrl.sv
      - hdl/sa_controller.sv
      - hdl/systolic_array.sv
      - hdl/sparhixcel_top.sv
  - target: simulation
    files:
      - verification/tb_sparhixcel.sv

/* verification/tb_sparhixcel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sparhixcel
    import sa_array_pkg::*;
    import sa_ctrl_pkg::*;
();

    localparam int CLK_HALF = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int DRAM_DEPTH = 128;
    localparam int N_RANDOM = 8;
    localparam int N_RUNS = N_RANDOM + 2;
    localparam int TIMEOUT_CYCLES = N_RUNS * 120 + 200;

    logic                       clk_i;
    logic                       rd_weight_rst;
    logic                       start_i;
    logic [DRAM_WORD_WIDTH-1:0] mem_data_i;
    logic                       dram_rd_en_o;
    logic [DRAM_ADDR_WIDTH-1:0] dram_rd_address_o;
    logic                       busy_o;
    logic                       final_valid_o;
    acc_t                       final_output_o;

    // DRAM contents and the read waiting for its data
    logic [DRAM_WORD_WIDTH-1:0] dram [DRAM_DEPTH];
    logic                       pend_en;
    logic [DRAM_ADDR_WIDTH-1:0] pend_addr;

    logic [15:0]                lfsr_q = 16'd6;
    logic [DRAM_ADDR_WIDTH-1:0] addr_q [$];
    int                         fv_count;
    int                         cycle_cnt;
    logic                       prev_fv;
    acc_t                       last_result;
    acc_t                       held_result;

    sparhixcel_top UUT (
        .clk_i            (clk_i),
        .rd_weight_rst    (rd_weight_rst),
        .start_i          (start_i),
        .mem_data_i       (mem_data_i),
        .dram_rd_en_o     (dram_rd_en_o),
        .dram_rd_address_o(dram_rd_address_o),
        .busy_o           (busy_o),
        .final_valid_o    (final_valid_o),
        .final_output_o   (final_output_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    ////////////////////
    // failure reporting
    ////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, actual, expected);
            report_failure("value check failed");
        end
    endtask

    ////////////////////
    // random numbers
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
        return value;
    endfunction

    ////////////////////
    // DRAM model
    ////////////////////

    task automatic fill_dram(input logic [3:0] last_row, input bit extreme);
        logic [31:0] word;
        for (int a = 0; a < DRAM_DEPTH; a++) begin
            word = rand_bits(32);
            if (extreme) begin
                for (int b = 0; b < 4; b++) begin
                    word[8*b +: 8] = rand_bits(1) ? 8'h80 : 8'h7f;
                end
            end
            dram[a] = word;
        end
        word = rand_bits(28);
        dram[PARAM_ADDR] = {word[27:0], last_row};
    endtask

    // data for a read shows up in the following cycle
    always @(posedge clk_i) begin
        #DRIVE_DELAY;
        if (pend_en && (int'(pend_addr) >= DRAM_DEPTH)) begin
            report_failure("DUT read a DRAM address outside the modeled range");
        end else if (pend_en) begin
            mem_data_i = dram[int'(pend_addr)];
        end else begin
            mem_data_i = '0;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    // signed dot product over all rows and lanes wrapped to 16 bits
    function automatic logic [15:0] expected_sum(input int rows);
        int                total;
        logic [63:0]       w_row;
        logic [63:0]       f_row;
        logic signed [7:0] w_lane;
        logic signed [7:0] f_lane;
        total = 0;
        for (int r = 0; r < rows; r++) begin
            w_row = {dram[WEIGHT_BASE + 2*r + 1], dram[WEIGHT_BASE + 2*r]};
            f_row = {dram[INPUT_BASE + 2*r + 1], dram[INPUT_BASE + 2*r]};
            for (int l = 0; l < 8; l++) begin
                w_lane = w_row[8*l +: 8];
                f_lane = f_row[8*l +: 8];
                total  = total + w_lane * f_lane;
            end
        end
        return total[15:0];
    endfunction

    ////////////////////
    // output monitor
    ////////////////////

    always @(negedge clk_i) begin
        pend_en   = dram_rd_en_o;
        pend_addr = dram_rd_address_o;
        if (!rd_weight_rst) begin
            if (dram_rd_en_o) begin
                addr_q.push_back(dram_rd_address_o);
            end
            // busy drops right after the result pulse
            if (prev_fv) begin
                check("busy_o", busy_o, 1'b0);
            end
            if (final_valid_o) begin
                check("busy_o", busy_o, 1'b1);
                fv_count++;
                last_result = final_output_o;
                held_result = final_output_o;
            end else begin
                check("final_output_o", final_output_o, held_result);
            end
            prev_fv = final_valid_o;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure("simulation timed out before all runs finished");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic tick();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic check_addresses(input int rows);
        check("dram read count", addr_q.size(), 1 + 4*rows);
        check("dram_rd_address_o", addr_q[0], PARAM_ADDR);
        for (int i = 0; i < 2*rows; i++) begin
            check("dram_rd_address_o", addr_q[1 + i], WEIGHT_BASE + i);
            check("dram_rd_address_o", addr_q[1 + 2*rows + i], INPUT_BASE + i);
        end
    endtask

    task automatic run_once(input logic [3:0] last_row, input bit extreme);
        int   rows;
        int   fv_before;
        acc_t expected;
        rows = last_row + 1;
        fill_dram(last_row, extreme);
        expected = expected_sum(rows);
        addr_q.delete();
        fv_before = fv_count;
        start_i = 1'b1;
        tick();
        start_i = 1'b0;
        repeat (3) tick();
        // second start while loading
        check("busy_o", busy_o, 1'b1);
        start_i = 1'b1;
        tick();
        start_i = 1'b0;
        while (fv_count == fv_before) begin
            tick();
        end
        check("final_output_o", last_result, expected);
        check_addresses(rows);
        repeat (4) tick();
        check("final_valid_o count", fv_count, fv_before + 1);
    endtask

    initial begin
        logic [3:0] rows_m1;
        rd_weight_rst = 1'b1;
        start_i       = 1'b0;
        mem_data_i    = '0;
        pend_en       = 1'b0;
        pend_addr     = '0;
        fv_count      = 0;
        cycle_cnt     = 0;
        prev_fv       = 1'b0;
        last_result   = '0;
        held_result   = '0;
        repeat (8) tick();
        check("busy_o", busy_o, 1'b0);
        check("dram_rd_en_o", dram_rd_en_o, 1'b0);
        check("final_valid_o", final_valid_o, 1'b0);
        check("dram_rd_address_o", dram_rd_address_o, '0);
        check("final_output_o", final_output_o, '0);
        rd_weight_rst = 1'b0;
        repeat (2) tick();

        // extreme lanes at the smallest and largest row counts
        run_once(4'd0, 1'b1);
        run_once(4'd15, 1'b1);

        for (int run = 0; run < N_RANDOM; run++) begin
            rows_m1 = rand_bits(4);
            run_once(rows_m1, 1'b0);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/sparhixcel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sparhixcel_top
    import sa_array_pkg::*;
    import sa_ctrl_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rd_weight_rst,
    input  logic                       start_i,
    input  logic [DRAM_WORD_WIDTH-1:0] mem_data_i,
    output logic                       dram_rd_en_o,
    output logic [DRAM_ADDR_WIDTH-1:0] dram_rd_address_o,
    output logic                       busy_o,
    output logic                       final_valid_o,
    output acc_t                       final_output_o
);

    logic         weight_word_valid;
    logic         input_word_valid;
    logic         weight_restart;
    logic         input_restart;
    logic         compute_start;
    logic         compute_done;
    layer_param_t layer_param;
    row_wr_t      weight_wr;
    row_wr_t      input_wr;
    row_rd_t      row_rd;
    weight_row_t  weight_row;
    feature_row_t feature_row;
    logic         rd_weight_ld;
    logic         acc_clear;
    logic         acc_en;

    ////////////////////
    // load path
    ////////////////////

    dram_access_ctrl dram_access_controller (
        .clk_i              (clk_i),
        .rd_weight_rst      (rd_weight_rst),
        .start_i            (start_i),
        .mem_data_i         (mem_data_i),
        .compute_done_i     (compute_done),
        .dram_rd_en_o       (dram_rd_en_o),
        .dram_rd_address_o  (dram_rd_address_o),
        .busy_o             (busy_o),
        .weight_word_valid_o(weight_word_valid),
        .input_word_valid_o (input_word_valid),
        .weight_restart_o   (weight_restart),
        .input_restart_o    (input_restart),
        .compute_start_o    (compute_start),
        .layer_param_o      (layer_param)
    );

    dram_to_memory #(.OUT_WORDS(WORDS_PER_ROW)) dram_to_mem_weight (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .word_valid_i (weight_word_valid),
        .restart_i    (weight_restart),
        .data_in_i    (mem_data_i),
        .row_wr_o     (weight_wr)
    );

    dram_to_memory #(.OUT_WORDS(WORDS_PER_ROW)) dram_to_mem_input (
        .clk_i        (clk_i),
        .rd_weight_rst(rd_weight_rst),
        .word_valid_i (input_word_valid),
        .restart_i    (input_restart),
        .data_in_i    (mem_data_i),
        .row_wr_o     (input_wr)
    );

    simple_dual_port_ram #(
        .MEMORY_WIDTH($bits(weight_row_t)),
        .ADDRS_WIDTH (ROW_ADDR_WIDTH)
    ) weight_memory (
        .clk_i(clk_i),
        .wr_i (weight_wr),
        .rd_i (row_rd),
        .dob_o(weight_row)
    );

    simple_dual_port_ram #(
        .MEMORY_WIDTH($bits(feature_row_t)),
        .ADDRS_WIDTH (ROW_ADDR_WIDTH)
    ) in_feature_memory (
        .clk_i(clk_i),
        .wr_i (input_wr),
        .rd_i (row_rd),
        .dob_o(feature_row)
    );

    ////////////////////
    // compute path
    ////////////////////

    sa_controller control_block (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .compute_start_i(compute_start),
        .layer_param_i  (layer_param),
        .row_rd_o       (row_rd),
        .rd_weight_ld_o (rd_weight_ld),
        .acc_clear_o    (acc_clear),
        .acc_en_o       (acc_en),
        .final_valid_o  (final_valid_o),
        .compute_done_o (compute_done)
    );

    systolic_array array_block (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .in_feature_i  (feature_row),
        .f_weight_i    (weight_row),
        .rd_weight_ld_i(rd_weight_ld),
        .acc_clear_i   (acc_clear),
        .acc_en_i      (acc_en),
        .result_o      (final_output_o)
    );

endmodule

`default_nettype wire

/* hdl/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_array
    import sa_array_pkg::*;
(
    input  logic         clk_i,
    input  logic         rd_weight_rst,
    input  feature_row_t in_feature_i,
    input  weight_row_t  f_weight_i,
    input  logic         rd_weight_ld_i,
    input  logic         acc_clear_i,
    input  logic         acc_en_i,
    output acc_t         result_o
);

    weight_row_t  weight_q;
    feature_row_t feature_q;
    prod_row_t    prod_q;
    acc_t         lane_sum;
    acc_t         sum_q;
    acc_t         acc_q;
    acc_t         result_q;

    ////////////////////
    // operand registers
    ////////////////////

    // feature is captured with the weight so both rows line up
    always_ff @(posedge clk_i) begin
        if (rd_weight_ld_i) begin
            weight_q  <= f_weight_i;
            feature_q <= in_feature_i;
        end
    end

    ////////////////////
    // lane products and adder stage
    ////////////////////

    always_ff @(posedge clk_i) begin
        for (int lane = 0; lane < N_LANES; lane++) begin
            prod_q[lane] <= $signed(weight_q[lane]) * $signed(feature_q[lane]);
        end
    end

    // wraps modulo 2^16
    always_comb begin
        lane_sum = '0;
        for (int lane = 0; lane < N_LANES; lane++) begin
            lane_sum = lane_sum + prod_q[lane];
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q <= lane_sum;
    end

    ////////////////////
    // accumulator
    ////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            acc_q    <= '0;
            result_q <= '0;
        end else if (acc_en_i) begin
            if (acc_clear_i) begin
                // last row: publish the total, start the next run from zero
                result_q <= acc_q + sum_q;
                acc_q    <= '0;
            end else begin
                acc_q <= acc_q + sum_q;
            end
        end
    end

    // held between runs
    assign result_o = result_q;

endmodule

`default_nettype wire

/* hdl/sa_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_controller
    import sa_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         rd_weight_rst,
    input  logic         compute_start_i,
    input  layer_param_t layer_param_i,
    output row_rd_t      row_rd_o,
    output logic         rd_weight_ld_o,
    output logic         acc_clear_o,
    output logic         acc_en_o,
    output logic         final_valid_o,
    output logic         compute_done_o
);

    sa_state_t                 state_q;
    logic                      rd_en_q;
    logic [ROW_ADDR_WIDTH-1:0] row_cnt_q;
    logic                      at_last_row;
    logic                      ld_q;
    logic                      ld_last_q;
    logic [2:0]                valid_pipe_q;
    logic [2:0]                last_pipe_q;
    logic                      final_valid_q;

    assign at_last_row = (row_cnt_q == layer_param_i.last_row);

    ////////////////////
    // row read FSM
    ////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q   <= SA_IDLE;
            rd_en_q   <= 1'b0;
            row_cnt_q <= '0;
        end else begin
            case (state_q)
                SA_IDLE: begin
                    if (compute_start_i) begin
                        rd_en_q   <= 1'b1;
                        row_cnt_q <= '0;
                        state_q   <= SA_STREAM;
                    end
                end
                SA_STREAM: begin
                    if (at_last_row) begin
                        rd_en_q <= 1'b0;
                        state_q <= SA_DRAIN;
                    end else begin
                        row_cnt_q <= row_cnt_q + 1'b1;
                    end
                end
                SA_DRAIN: begin
                    // leave on the closing accumulate
                    if (acc_clear_o) begin
                        state_q <= SA_IDLE;
                    end
                end
                default: state_q <= SA_IDLE;
            endcase
        end
    end

    // rows in flight: load, product, sum, with the last row flagged alongside
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            ld_q          <= 1'b0;
            ld_last_q     <= 1'b0;
            valid_pipe_q  <= '0;
            last_pipe_q   <= '0;
            final_valid_q <= 1'b0;
        end else begin
            ld_q          <= rd_en_q;
            ld_last_q     <= rd_en_q && at_last_row;
            valid_pipe_q  <= {valid_pipe_q[1:0], ld_q};
            last_pipe_q   <= {last_pipe_q[1:0], ld_last_q};
            final_valid_q <= acc_clear_o;
        end
    end

    assign row_rd_o.en   = rd_en_q;
    assign row_rd_o.addr = row_cnt_q;

    assign rd_weight_ld_o = ld_q;
    assign acc_en_o       = valid_pipe_q[2];
    // last row closes the sum and resets the accumulator for the next run
    assign acc_clear_o    = valid_pipe_q[2] & last_pipe_q[2];
    assign final_valid_o  = final_valid_q;
    assign compute_done_o = final_valid_q;

endmodule

`default_nettype wire

/* hdl/dram_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_access_ctrl
    import sa_ctrl_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rd_weight_rst,
    input  logic                       start_i,
    input  logic [DRAM_WORD_WIDTH-1:0] mem_data_i,
    input  logic                       compute_done_i,
    output logic                       dram_rd_en_o,
    output logic [DRAM_ADDR_WIDTH-1:0] dram_rd_address_o,
    output logic                       busy_o,
    output logic                       weight_word_valid_o,
    output logic                       input_word_valid_o,
    output logic                       weight_restart_o,
    output logic                       input_restart_o,
    output logic                       compute_start_o,
    output layer_param_t               layer_param_o
);

    dram_phase_t                phase_q;
    dram_phase_t                rd_phase_q;
    dram_phase_t                word_phase_q;
    logic                       rd_en_q;
    logic                       rd_first_q;
    logic [DRAM_ADDR_WIDTH-1:0] rd_addr_q;
    logic                       word_valid_q;
    logic                       word_first_q;
    logic                       compute_start_q;
    logic [WORD_CNT_WIDTH-1:0]  word_cnt_q;
    logic [WORD_CNT_WIDTH-1:0]  last_word;
    logic                       param_word;
    layer_param_t               layer_param_q;

    // index of the last word in a weight or input block
    assign last_word = WORD_CNT_WIDTH'(WORDS_PER_ROW * (layer_param_q.last_row + 1) - 1);
    assign param_word = word_valid_q && (word_phase_q == PH_PARAM);

    ////////////////////
    // read sequencer
    ////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            phase_q         <= PH_IDLE;
            rd_phase_q      <= PH_IDLE;
            rd_en_q         <= 1'b0;
            rd_first_q      <= 1'b0;
            rd_addr_q       <= '0;
            word_cnt_q      <= '0;
            compute_start_q <= 1'b0;
            layer_param_q   <= '0;
        end else begin
            compute_start_q <= 1'b0;
            rd_first_q      <= 1'b0;
            case (phase_q)
                PH_IDLE: begin
                    if (start_i) begin
                        rd_en_q    <= 1'b1;
                        rd_addr_q  <= PARAM_ADDR;
                        rd_phase_q <= PH_PARAM;
                        phase_q    <= PH_PARAM;
                    end
                end
                PH_PARAM: begin
                    // hold off until the row count is known
                    rd_en_q <= 1'b0;
                    if (param_word) begin
                        layer_param_q.last_row <= mem_data_i[ROW_ADDR_WIDTH-1:0];
                        rd_en_q    <= 1'b1;
                        rd_addr_q  <= WEIGHT_BASE;
                        rd_phase_q <= PH_WEIGHT;
                        rd_first_q <= 1'b1;
                        word_cnt_q <= '0;
                        phase_q    <= PH_WEIGHT;
                    end
                end
                PH_WEIGHT: begin
                    word_cnt_q <= word_cnt_q + 1'b1;
                    rd_addr_q  <= rd_addr_q + 1'b1;
                    if (word_cnt_q == last_word) begin
                        rd_addr_q  <= INPUT_BASE;
                        rd_phase_q <= PH_INPUT;
                        rd_first_q <= 1'b1;
                        word_cnt_q <= '0;
                        phase_q    <= PH_INPUT;
                    end
                end
                PH_INPUT: begin
                    word_cnt_q <= word_cnt_q + 1'b1;
                    if (word_cnt_q < last_word) begin
                        rd_addr_q <= rd_addr_q + 1'b1;
                    end else begin
                        rd_en_q <= 1'b0;
                    end
                    // two extra cycles cover the returning word and its row write
                    if (word_cnt_q == last_word + 2'd2) begin
                        compute_start_q <= 1'b1;
                        phase_q         <= PH_COMPUTE;
                    end
                end
                PH_COMPUTE: begin
                    if (compute_done_i) begin
                        phase_q <= PH_IDLE;
                    end
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // returning word tags, fixed one cycle DRAM latency
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            word_valid_q <= 1'b0;
            word_first_q <= 1'b0;
            word_phase_q <= PH_IDLE;
        end else begin
            word_valid_q <= rd_en_q;
            word_first_q <= rd_first_q;
            word_phase_q <= rd_phase_q;
        end
    end

    assign weight_word_valid_o = word_valid_q && (word_phase_q == PH_WEIGHT);
    assign input_word_valid_o  = word_valid_q && (word_phase_q == PH_INPUT);
    assign weight_restart_o    = weight_word_valid_o && word_first_q;
    assign input_restart_o     = input_word_valid_o && word_first_q;

    assign dram_rd_en_o      = rd_en_q;
    assign dram_rd_address_o = rd_addr_q;
    assign busy_o            = (phase_q != PH_IDLE);
    assign compute_start_o   = compute_start_q;
    assign layer_param_o     = layer_param_q;

endmodule

`default_nettype wire

/* hdl/dram_to_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_to_memory
    import sa_ctrl_pkg::*;
#(
    parameter int OUT_WORDS = 2
) (
    input  logic                       clk_i,
    input  logic                       rd_weight_rst,
    input  logic                       word_valid_i,
    input  logic                       restart_i,
    input  logic [DRAM_WORD_WIDTH-1:0] data_in_i,
    output row_wr_t                    row_wr_o
);

    logic [OUT_WORDS*DRAM_WORD_WIDTH-1:0] shift_q;
    logic [$clog2(OUT_WORDS+1)-1:0]       word_cnt_q;
    logic [$clog2(OUT_WORDS+1)-1:0]       cnt_base;
    logic [ROW_ADDR_WIDTH-1:0]            row_cnt_q;
    logic                                 wr_en_q;

    // first word of a phase starts a fresh row
    assign cnt_base = restart_i ? '0 : word_cnt_q;

    // words enter at the top, so the first word ends up low
    always_ff @(posedge clk_i) begin
        if (word_valid_i) begin
            shift_q <= {data_in_i, shift_q[OUT_WORDS*DRAM_WORD_WIDTH-1:DRAM_WORD_WIDTH]};
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            word_cnt_q <= '0;
            row_cnt_q  <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (word_valid_i) begin
                if (cnt_base == OUT_WORDS - 1) begin
                    wr_en_q    <= 1'b1;
                    word_cnt_q <= '0;
                end else begin
                    word_cnt_q <= cnt_base + 1'b1;
                end
            end
            if (restart_i) begin
                row_cnt_q <= '0;
            end else if (wr_en_q) begin
                row_cnt_q <= row_cnt_q + 1'b1;
            end
        end
    end

    assign row_wr_o.en   = wr_en_q;
    assign row_wr_o.addr = row_cnt_q;
    assign row_wr_o.data = shift_q;

endmodule

`default_nettype wire

/* hdl/simple_dual_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_dual_port_ram
    import sa_ctrl_pkg::*;
#(
    parameter int MEMORY_WIDTH = DRAM_WORD_WIDTH * WORDS_PER_ROW,
    parameter int ADDRS_WIDTH  = ROW_ADDR_WIDTH
) (
    input  logic                    clk_i,
    input  row_wr_t                 wr_i,
    input  row_rd_t                 rd_i,
    output logic [MEMORY_WIDTH-1:0] dob_o
);

    logic [MEMORY_WIDTH-1:0] mem_q [2**ADDRS_WIDTH];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem_q[wr_i.addr] <= wr_i.data;
        end
    end

    ////////////////////
    // read port, data one cycle after enable
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rd_i.en) begin
            dob_o <= mem_q[rd_i.addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/sa_ctrl_pkg.sv */
`default_nettype none

package sa_ctrl_pkg;

    import sa_array_pkg::*;

    ////////////////////
    // DRAM map
    ////////////////////

    localparam int DRAM_WORD_WIDTH = 32;
    localparam int DRAM_ADDR_WIDTH = 18;

    // two DRAM words per stored row, low word first
    localparam int WORDS_PER_ROW = 2;

    localparam int MAX_ROWS = 16;
    localparam int ROW_ADDR_WIDTH = $clog2(MAX_ROWS);

    // wide enough to count one block of words plus the write drain
    localparam int WORD_CNT_WIDTH = $clog2(WORDS_PER_ROW * MAX_ROWS + 3);

    localparam logic [DRAM_ADDR_WIDTH-1:0] PARAM_ADDR = 18'd0;
    localparam logic [DRAM_ADDR_WIDTH-1:0] WEIGHT_BASE = 18'd16;
    localparam logic [DRAM_ADDR_WIDTH-1:0] INPUT_BASE = 18'd64;

    ////////////////////
    // FSM states
    ////////////////////

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PARAM,
        PH_WEIGHT,
        PH_INPUT,
        PH_COMPUTE
    } dram_phase_t;

    typedef enum logic [1:0] {
        SA_IDLE,
        SA_STREAM,
        SA_DRAIN
    } sa_state_t;

    ////////////////////
    // control bundles
    ////////////////////

    // row count minus one, from parameter word bits 3:0
    typedef struct packed {
        logic [ROW_ADDR_WIDTH-1:0] last_row;
    } layer_param_t;

    typedef struct packed {
        logic                      en;
        logic [ROW_ADDR_WIDTH-1:0] addr;
        logic [ROW_WIDTH-1:0]      data;
    } row_wr_t;

    typedef struct packed {
        logic                      en;
        logic [ROW_ADDR_WIDTH-1:0] addr;
    } row_rd_t;

endpackage

`default_nettype wire

/* hdl/sa_array_pkg.sv */
`default_nettype none

package sa_array_pkg;

    ////////////////////
    // array geometry
    ////////////////////

    // lanes per stored row
    localparam int N_LANES = 8;

    // feature and weight lane widths
    localparam int I_WIDTH = 8;
    localparam int F_WIDTH = 8;

    // product, lane sum and accumulator width
    localparam int ACC_WIDTH = 16;

    // one stored row in bits
    localparam int ROW_WIDTH = N_LANES * I_WIDTH;

    ////////////////////
    // lane and row types
    ////////////////////

    typedef logic signed [I_WIDTH-1:0] feature_t;
    typedef logic signed [F_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // lane 0 sits in the low byte
    typedef feature_t [N_LANES-1:0] feature_row_t;
    typedef weight_t [N_LANES-1:0] weight_row_t;

    // one product per lane
    typedef acc_t [N_LANES-1:0] prod_row_t;

endpackage

`default_nettype wire
